// File: Makefile
TOP := uart_loopback_tb
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: list.f
+incdir+logic
logic/uart_pkg.sv
logic/loop_pkg.sv
logic/uart_host_if.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_core.sv
logic/loopback_ctrl.sv
logic/uart_loopback.sv
testbench/tb_clock.sv
testbench/uart_loopback_assertions.sv
testbench/uart_loopback_tb.sv

// File: logic/loop_pkg.sv
// loopback controller types
// state of the read-then-echo loop

package loop_pkg;

   // recv_char waits for a byte, send_char waits for the transmitter
   typedef enum logic {
      recv_char,   // buffer poll
      send_char    // wait on busy, then write
   } loop_state_t;

endpackage

// File: logic/loopback_ctrl.sv
// loopback controller
// reads each received byte, shows it on led and writes it back to the uart
module loopback_ctrl (
   input  logic                 clk,
   input  logic                 reset,
   uart_host_if.client          host,
   output uart_pkg::uart_byte_t led
);
   import loop_pkg::*;

   loop_state_t state;

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= recv_char;
         host.rd <= 1'b0;
         host.wr <= 1'b0;
         led     <= '0;
      end else begin
         case (state)
            recv_char: begin
               host.rd <= 1'b0;
               host.wr <= 1'b0;         // ends the write pulse
               if (host.valid) begin
                  host.rd <= 1'b1;      // take the byte
                  led     <= host.rx_data;
                  state   <= send_char;
               end
            end
            send_char: begin
               host.rd <= 1'b0;
               // byte stays here while the last echo is still going out
               if (!host.busy) begin
                  host.wr <= 1'b1;
                  state   <= recv_char;
               end
            end
            default: begin
               host.rd <= 1'b0;
               host.wr <= 1'b0;
               state   <= recv_char;
            end
         endcase
      end
   end

   // echo byte, latched together with led
   always_ff @(posedge clk) begin
      if (state == recv_char && host.valid)
         host.tx_data <= host.rx_data;
   end

endmodule

// File: logic/uart_core.sv
// uart core
// receiver and transmitter behind the host strobes, with a one-byte rx buffer
module uart_core (
   input  logic        clk,
   input  logic        reset,
   input  logic        rxd,
   output logic        txd,
   uart_host_if.core   host
);
   import uart_pkg::*;

   logic       rx_done;    // one-cycle, good stop bit only
   uart_byte_t rx_byte;
   uart_byte_t rx_buf;     // holding buffer
   logic       tx_start;

   uart_rx u_uart_rx (
      .clk   (clk),
      .reset (reset),
      .rxd   (rxd),
      .done  (rx_done),
      .data  (rx_byte)
   );

   // a write during a frame is dropped
   assign tx_start = host.wr & ~host.busy;

   uart_tx u_uart_tx (
      .clk   (clk),
      .reset (reset),
      .start (tx_start),
      .data  (host.tx_data),
      .txd   (txd),
      .busy  (host.busy)
   );

   // new byte wins over a read in the same cycle
   always_ff @(posedge clk) begin
      if (reset)
         host.valid <= 1'b0;
      else if (rx_done)
         host.valid <= 1'b1;
      else if (host.rd)
         host.valid <= 1'b0;   // low the cycle after rd
   end

   always_ff @(posedge clk) begin
      if (rx_done) rx_buf <= rx_byte;   // overwrites an unread byte
   end

   assign host.rx_data = rx_buf;

endmodule

// File: logic/uart_host_if.sv
// uart host side
// read/write strobes from the client, status levels and data from the core
interface uart_host_if;
   import uart_pkg::*;

   logic       rd;        // one-cycle read strobe, empties the buffer
   logic       wr;        // one-cycle write strobe, starts a frame
   logic       valid;     // buffer holds a byte
   logic       busy;      // frame on txd
   uart_byte_t rx_data;   // received byte
   uart_byte_t tx_data;   // byte to send

   // the uart side
   modport core (
      input  rd,
      input  wr,
      input  tx_data,
      output valid,
      output busy,
      output rx_data
   );

   // the loopback side
   modport client (
      output rd,
      output wr,
      output tx_data,
      input  valid,
      input  busy,
      input  rx_data
   );

endinterface

// File: logic/uart_loopback.sv
// serial loopback top
// every byte received on rxd is shown on led and sent back on txd
`include "uart_settings.svh"

module uart_loopback (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       rxd,    // serial in, idles high
   output logic                       txd,    // serial out, idles high
   output logic [`UART_DATA_BITS-1:0] led     // last echoed byte
);

   // strobes, status and data between core and controller
   uart_host_if host ();

   // uart with its one-byte receive buffer
   uart_core u_uart_core (
      .clk   (clk),
      .reset (reset),
      .rxd   (rxd),
      .txd   (txd),
      .host  (host.core)
   );

   // read, latch, write back
   loopback_ctrl u_loopback_ctrl (
      .clk   (clk),
      .reset (reset),
      .host  (host.client),
      .led   (led)
   );

endmodule

// File: logic/uart_pkg.sv
// uart line types
// data bytes, bit and baud counters, receiver and transmitter states
`include "uart_settings.svh"

package uart_pkg;

   typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;   // one byte on the line
   typedef logic [3:0] bit_count_t;                   // data bit index in a frame

   // clocks within one bit
   typedef logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_count_t;

   // receiver line states
   typedef enum logic [1:0] {rxs_idle, rxs_start, rxs_data, rxs_stop} rx_state_t;

   // transmitter line states
   typedef enum logic [1:0] {txs_idle, txs_start, txs_data, txs_stop} tx_state_t;

endpackage

// File: logic/uart_rx.sv
// uart receiver
// 8N1 frames sampled at mid-bit, byte dropped on a low stop bit
`include "uart_settings.svh"

module uart_rx (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 rxd,
   output logic                 done,
   output uart_pkg::uart_byte_t data
);
   import uart_pkg::*;

   localparam baud_count_t bit_end  = baud_count_t'(`UART_CLKS_PER_BIT - 1);
   localparam baud_count_t half_end = baud_count_t'(`UART_CLKS_PER_BIT / 2 - 1);
   localparam baud_count_t stop_end = baud_count_t'(`UART_CLKS_PER_BIT / 2 - 2);
   localparam bit_count_t  last_bit = bit_count_t'(`UART_DATA_BITS - 1);

   rx_state_t   state;
   baud_count_t baud_cnt;     // clocks since last sample point
   bit_count_t  bit_idx;      // next data bit
   logic        rxd_meta;
   logic        rxd_s;        // synchronized line
   logic        mid_seen;     // stop bit sampled, now in its second half
   logic        stop_ok;

   // two-flop sync, line idles high
   always_ff @(posedge clk) begin
      if (reset) begin
         rxd_meta <= 1'b1;
         rxd_s    <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_s    <= rxd_meta;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= rxs_idle;
         baud_cnt <= '0;
         bit_idx  <= '0;
         mid_seen <= 1'b0;
         stop_ok  <= 1'b0;
         done     <= 1'b0;
      end else begin
         done     <= 1'b0;
         baud_cnt <= baud_cnt + 1'b1;
         case (state)
            rxs_idle: begin
               baud_cnt <= '0;
               bit_idx  <= '0;
               mid_seen <= 1'b0;
               if (!rxd_s) state <= rxs_start;   // high to low, start edge
            end
            rxs_start: if (baud_cnt == half_end) begin
               baud_cnt <= '0;
               state    <= rxd_s ? rxs_idle : rxs_data;   // glitch if high again
            end
            rxs_data: if (baud_cnt == bit_end) begin
               baud_cnt <= '0;
               bit_idx  <= bit_idx + 1'b1;
               if (bit_idx == last_bit) state <= rxs_stop;
            end
            rxs_stop: begin
               if (!mid_seen && baud_cnt == bit_end) begin
                  baud_cnt <= '0;
                  mid_seen <= 1'b1;
                  stop_ok  <= rxd_s;             // stop bit level
               end else if (mid_seen && baud_cnt == stop_end) begin
                  done  <= stop_ok;              // lands half a bit after mid stop
                  state <= rxs_idle;
               end
            end
            default: state <= rxs_idle;
         endcase
      end
   end

   // lsb arrives first, shift in from the top
   always_ff @(posedge clk) begin
      if (state == rxs_data && baud_cnt == bit_end)
         data <= {rxd_s, data[`UART_DATA_BITS-1:1]};
   end

endmodule

// File: logic/uart_settings.svh
// uart line settings
// bit timing and frame width shared by the serial blocks
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// clocks per serial bit, 4 or more
// half of it sets the mid-bit sample point
`define UART_CLKS_PER_BIT 16

// data bits per frame, lsb goes out first
`define UART_DATA_BITS 8

`endif

// File: logic/uart_tx.sv
// uart transmitter
// 8N1 frames, start bit on the cycle after start, busy through the stop bit
`include "uart_settings.svh"

module uart_tx (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  uart_pkg::uart_byte_t data,
   output logic                 txd,
   output logic                 busy
);
   import uart_pkg::*;

   localparam baud_count_t bit_end  = baud_count_t'(`UART_CLKS_PER_BIT - 1);
   localparam bit_count_t  last_bit = bit_count_t'(`UART_DATA_BITS - 1);

   tx_state_t   state;
   baud_count_t baud_cnt;
   bit_count_t  bit_idx;    // data bit on the line
   uart_byte_t  shifter;    // bit 0 is on txd

   assign busy = (state != txs_idle);   // low only when txd idles high

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= txs_idle;
         baud_cnt <= '0;
         bit_idx  <= '0;
         txd      <= 1'b1;
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
         case (state)
            txs_idle: begin
               baud_cnt <= '0;
               bit_idx  <= '0;
               if (start) begin
                  txd   <= 1'b0;               // start bit
                  state <= txs_start;
               end
            end
            txs_start: if (baud_cnt == bit_end) begin
               baud_cnt <= '0;
               txd      <= shifter[0];         // first data bit
               state    <= txs_data;
            end
            txs_data: if (baud_cnt == bit_end) begin
               baud_cnt <= '0;
               bit_idx  <= bit_idx + 1'b1;
               if (bit_idx == last_bit) begin
                  txd   <= 1'b1;               // stop bit
                  state <= txs_stop;
               end else begin
                  txd <= shifter[1];           // next bit, shifter moves below
               end
            end
            txs_stop: if (baud_cnt == bit_end) state <= txs_idle;
            default: state <= txs_idle;
         endcase
      end
   end

   // load on start, shift right at each data bit end
   always_ff @(posedge clk) begin
      if (state == txs_idle && start)
         shifter <= data;
      else if (state == txs_data && baud_cnt == bit_end)
         shifter <= shifter >> 1;
   end

endmodule

// File: testbench/tb_clock.sv
// testbench clock
// free-running 100 ns clock
module tb_clock #(
   parameter int period_ns = 100
) (
   output logic clk
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;   // half period high, half low
   end

endmodule

// File: testbench/uart_loopback_assertions.sv
// loopback protocol checks
// host strobes and serial line rules, bound into the uart core
module uart_loopback_assertions (
   input logic clk,
   input logic reset,
   input logic rd,
   input logic wr,
   input logic valid,
   input logic busy,
   input logic rx_done,
   input logic txd
);
   timeunit 1ns;
   timeprecision 1ps;

   // strobes are single-cycle pulses
   rd_pulse: assert property (@(posedge clk) disable iff (reset) rd |=> !rd)
      else $error("rd stayed high for more than one cycle");

   wr_pulse: assert property (@(posedge clk) disable iff (reset) wr |=> !wr)
      else $error("wr stayed high for more than one cycle");

   // controller must wait for the transmitter
   wr_not_busy: assert property (@(posedge clk) disable iff (reset) wr |-> !busy)
      else $error("wr given while the transmitter was busy");

   // a new byte in the same cycle keeps valid up
   rd_clears_valid: assert property (@(posedge clk) disable iff (reset)
      (rd && !rx_done) |=> !valid)
      else $error("valid still high the cycle after rd");

   // idle line
   txd_idle_high: assert property (@(posedge clk) disable iff (reset) !busy |-> txd)
      else $error("txd low while the transmitter was not busy");

endmodule

bind uart_core uart_loopback_assertions u_assertions (
   .clk     (clk),
   .reset   (reset),
   .rd      (host.rd),
   .wr      (host.wr),
   .valid   (host.valid),
   .busy    (host.busy),
   .rx_done (rx_done),
   .txd     (txd)
);

// File: testbench/uart_loopback_tb.sv
// serial loopback testbench
// table of frames onto rxd, txd decoded and compared in order, led checked per echo
`include "uart_settings.svh"

module uart_loopback_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import uart_pkg::*;

   localparam int clks_per_bit = `UART_CLKS_PER_BIT;
   localparam int num_rows     = 12;

   // one frame per row, gap in bit times, ff means a random gap
   typedef struct packed {
      uart_byte_t data;
      logic       stop;
      logic [7:0] gap;
   } frame_row_t;

   frame_row_t frames [num_rows] = '{
      '{8'h00, 1'b1, 8'd2},
      '{8'hff, 1'b1, 8'd2},
      '{8'h55, 1'b1, 8'd0},     // back to back from here
      '{8'haa, 1'b1, 8'd0},
      '{8'h3c, 1'b1, 8'd0},
      '{8'hc3, 1'b1, 8'hff},
      '{8'h5a, 1'b0, 8'd2},     // low stop bit, dropped
      '{8'ha5, 1'b1, 8'hff},
      '{8'h81, 1'b1, 8'hff},
      '{8'h7e, 1'b0, 8'd2},     // dropped again
      '{8'h12, 1'b1, 8'd0},
      '{8'he7, 1'b1, 8'd3}
   };

   logic       clk;
   logic       reset;
   logic       rxd;
   logic       txd;
   uart_byte_t led;

   uart_byte_t echo_q[$];       // bytes decoded from txd
   uart_byte_t led_q[$];        // led during each echo
   uart_byte_t expected_q[$];
   uart_byte_t last_good = '0;
   int         checks     = 0;
   int         mismatches = 0;
   int         failures   = 0;
   logic       timed_out  = 1'b0;

   tb_clock u_clock (.clk(clk));

   uart_loopback u_uart_loopback (
      .clk   (clk),
      .reset (reset),
      .rxd   (rxd),
      .txd   (txd),
      .led   (led)
   );

   // one bit time on rxd, level set on the rising edge
   task automatic drive_bit(input logic level);
      @(posedge clk);
      rxd <= level;
      repeat (clks_per_bit - 1) @(posedge clk);
   endtask

   task automatic send_frame(input uart_byte_t value, input logic stop_level,
                             input int gap_bits);
      drive_bit(1'b0);                                   // start
      for (int i = 0; i < `UART_DATA_BITS; i++) drive_bit(value[i]);   // lsb first
      drive_bit(stop_level);
      repeat (gap_bits) drive_bit(1'b1);                 // idle line
   endtask

   task automatic check_idle(input int cycles);
      for (int n = 0; n < cycles; n++) begin
         @(negedge clk);
         checks++;
         if (txd !== 1'b1) begin
            $display("Mismatch txd: got %h, expected %h at %0t", txd, 1'b1, $time);
            mismatches++;
         end
         if (led !== '0) begin
            $display("Mismatch led: got %h, expected %h at %0t", led, 8'h00, $time);
            mismatches++;
         end
      end
   endtask

   task automatic wait_for_echoes(input int count, input int limit_bits);
      int cycles;
      cycles = 0;
      while (echo_q.size() < count && cycles < limit_bits * clks_per_bit) begin
         @(negedge clk);
         cycles++;
      end
      if (echo_q.size() < count) begin
         $display("Timeout waiting for echo %0d, only %0d seen on txd", count, echo_q.size());
         failures++;
         timed_out = 1'b1;
      end
   endtask

   // txd decoder, samples at mid-bit on falling edges
   initial begin : txd_monitor
      uart_byte_t value;
      uart_byte_t led_seen;
      forever begin
         @(negedge clk);
         if (!reset && txd === 1'b0) begin
            repeat (clks_per_bit / 2) @(negedge clk);    // middle of start bit
            led_seen = led;
            if (txd !== 1'b0) begin
               $display("Start bit on txd ended before mid-bit at %0t", $time);
               failures++;
            end
            for (int i = 0; i < `UART_DATA_BITS; i++) begin
               repeat (clks_per_bit) @(negedge clk);
               value[i] = txd;
            end
            repeat (clks_per_bit) @(negedge clk);        // stop bit
            if (txd !== 1'b1) begin
               $display("Stop bit on txd was low at %0t", $time);
               failures++;
            end
            echo_q.push_back(value);
            led_q.push_back(led_seen);
         end
      end
   end

   initial begin : stimulus
      int gap_bits;
      reset = 1'b1;
      rxd   = 1'b1;
      void'($urandom(32'hbd6177f7));
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      check_idle(2 * clks_per_bit);                      // quiet line after reset

      for (int r = 0; r < num_rows && !timed_out; r++) begin
         gap_bits = (frames[r].gap == 8'hff) ? 1 + int'($urandom % 3) : int'(frames[r].gap);
         send_frame(frames[r].data, frames[r].stop, gap_bits);
         if (frames[r].stop) begin
            expected_q.push_back(frames[r].data);
            last_good = frames[r].data;
         end else begin
            // earlier echoes done, led must still hold the last good byte
            wait_for_echoes(expected_q.size(), 12 * num_rows);
            @(negedge clk);
            checks++;
            if (!timed_out && led !== last_good) begin
               $display("Mismatch led: got %h, expected %h after bad frame", led, last_good);
               mismatches++;
            end
         end
      end

      if (!timed_out) wait_for_echoes(expected_q.size(), 14 * num_rows);
      if (!timed_out) begin
         repeat (12 * clks_per_bit) @(negedge clk);      // room for a stray echo
         if (echo_q.size() != expected_q.size()) begin
            $display("Wrong number of echoes: %0d seen, %0d expected",
                     echo_q.size(), expected_q.size());
            failures++;
         end
         for (int k = 0; k < expected_q.size() && k < echo_q.size(); k++) begin
            checks++;
            if (echo_q[k] !== expected_q[k]) begin
               $display("Mismatch txd echo %0d: got %h, expected %h", k, echo_q[k],
                        expected_q[k]);
               mismatches++;
            end
            if (led_q[k] !== expected_q[k]) begin
               $display("Mismatch led at echo %0d: got %h, expected %h", k, led_q[k],
                        expected_q[k]);
               mismatches++;
            end
         end
         checks++;
         if (led !== last_good) begin
            $display("Mismatch led: got %h, expected %h at end", led, last_good);
            mismatches++;
         end
      end

      $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule
